// ==== hdl/bch_consts.svh ====
`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

// ==============================
// field sizes, gf(2^4)
// ==============================

// element width in bits
`define GF_M 4
// multiplicative order, 15 is also the log-form zero
`define GF_ORDER 15

// ==============================
// code sizes, bch(15) t=3
// ==============================

`define BCH_T 3
`define SYN_CNT 6
// working polynomial slots, up to x^6
`define POLY_LEN 7
// locator coefficients sigma0..sigma3
`define LOC_LEN 4

`endif

// ==== hdl/gf_pkg.sv ====
`include "bch_consts.svh"

package gf_pkg;

    // log form, k means alpha^k, GF_ORDER means zero
    typedef logic [`GF_M-1:0] gf_elem_t;
    // index = power of x
    typedef gf_elem_t [`POLY_LEN-1:0] gf_poly_t;

    // primitive poly x^4 + x + 1
    localparam logic [`GF_M-1:0] EXP_TBL [0:15] = '{
        4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h6, 4'hC, 4'hB,
        4'h5, 4'hA, 4'h7, 4'hE, 4'hF, 4'hD, 4'h9, 4'h0};
    localparam gf_elem_t LOG_TBL [0:15] = '{
        4'hF, 4'h0, 4'h1, 4'h4, 4'h2, 4'h8, 4'h5, 4'hA,
        4'h3, 4'hE, 4'h9, 4'h7, 4'h6, 4'hD, 4'hB, 4'hC};

    function automatic logic [`GF_M-1:0] gf_exp(gf_elem_t e);
        return EXP_TBL[e]; // zero code maps to 0
    endfunction

    function automatic gf_elem_t gf_log(logic [`GF_M-1:0] v);
        return LOG_TBL[v];
    endfunction

    function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
        logic [`GF_M:0] sum;
        if (a == gf_elem_t'(`GF_ORDER) || b == gf_elem_t'(`GF_ORDER)) begin
            return gf_elem_t'(`GF_ORDER);
        end
        sum = a + b;
        if (sum >= `GF_ORDER) sum = sum - `GF_ORDER;
        return sum[`GF_M-1:0];
    endfunction

    function automatic gf_elem_t gf_add(gf_elem_t a, gf_elem_t b);
        return gf_log(gf_exp(a) ^ gf_exp(b));
    endfunction

    // b must be nonzero
    function automatic gf_elem_t gf_div(gf_elem_t a, gf_elem_t b);
        logic [`GF_M:0] diff;
        if (a == gf_elem_t'(`GF_ORDER)) return gf_elem_t'(`GF_ORDER);
        diff = a + `GF_ORDER - b;
        if (diff >= `GF_ORDER) diff = diff - `GF_ORDER;
        return diff[`GF_M-1:0];
    endfunction

    // zero polynomial reports degree 0
    function automatic logic [2:0] poly_degree(gf_poly_t p);
        logic [2:0] deg;
        deg = '0;
        for (int i = 0; i < `POLY_LEN; i++) begin
            if (p[i] != gf_elem_t'(`GF_ORDER)) deg = 3'(i);
        end
        return deg;
    endfunction

endpackage

// ==== hdl/bch_pkg.sv ====
`include "bch_consts.svh"

package bch_pkg;

    // error locator, sigma0 at index 0
    typedef gf_pkg::gf_elem_t [`LOC_LEN-1:0] sigma_t;

    // bit position 0..14, 15 for an empty slot
    typedef logic [`GF_M-1:0] err_loc_t;

    typedef err_loc_t [`BCH_T-1:0] loc_list_t;

    // ==============================
    // key equation solver
    // ==============================

    typedef enum logic [1:0] {
        ST_IDLE,   // waiting for syndromes
        ST_DIVIDE, // divider running
        ST_UPDATE, // locator update, one quotient term per cycle
        ST_DONE    // sigma out
    } solver_state_t;

endpackage

// ==== hdl/bch_syndrome_load.sv ====
`include "bch_consts.svh"

module bch_syndrome_load (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  gf_pkg::gf_elem_t  in_syndrome,
    output logic              syn_valid,
    output gf_pkg::gf_poly_t  syn_poly
);
    import gf_pkg::*;

    localparam gf_elem_t ZERO_E = gf_elem_t'(`GF_ORDER);

    logic [2:0] cnt;
    gf_elem_t [`SYN_CNT-1:0] syn_shift;

    // count the six syndromes, pulse when the last one lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            syn_valid <= 1'b0;
        end else begin
            syn_valid <= 1'b0;
            if (in_valid) begin
                if (cnt == 3'(`SYN_CNT - 1)) begin
                    cnt       <= '0;
                    syn_valid <= 1'b1;
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

    // new value enters at the top, s1 ends up at power 0
    always_ff @(posedge clk) begin
        if (in_valid) begin
            syn_shift <= {in_syndrome, syn_shift[`SYN_CNT-1:1]};
        end
    end

    assign syn_poly = {ZERO_E, syn_shift}; // x^6 slot always zero

endmodule

// ==== hdl/gf_poly_divider.sv ====
`include "bch_consts.svh"

module gf_poly_divider (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  gf_pkg::gf_poly_t  dividend,
    input  gf_pkg::gf_poly_t  divisor,
    output logic              done,
    output gf_pkg::gf_poly_t  quotient,
    output gf_pkg::gf_poly_t  remainder
);
    import gf_pkg::*;

    localparam gf_elem_t ZERO_E = gf_elem_t'(`GF_ORDER);

    logic       busy;
    logic [2:0] dsr_deg;  // fixed for the whole division
    gf_poly_t   rem_q;
    gf_poly_t   quo_q;
    gf_poly_t   dsr_q;

    logic [2:0] rem_deg;
    logic [2:0] shift;
    gf_elem_t   coef;
    logic       finish;

    // next quotient term from the leading terms
    always_comb begin
        rem_deg = poly_degree(rem_q);
        finish  = (rem_q[rem_deg] == ZERO_E) || (rem_deg < dsr_deg);
        shift   = rem_deg - dsr_deg;
        coef    = gf_div(rem_q[rem_deg], dsr_q[dsr_deg]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (busy && finish) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // ==============================
    // one subtraction step per cycle
    // ==============================
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q   <= dividend;
            dsr_q   <= divisor;
            dsr_deg <= poly_degree(divisor);
            quo_q   <= '1; // all slots zero
        end else if (busy && !finish) begin
            quo_q[shift] <= coef;
            // subtract coef * x^shift * divisor, leading term cancels
            for (int i = 0; i < `POLY_LEN; i++) begin
                if (i >= int'(shift)) begin
                    rem_q[i] <= gf_add(rem_q[i], gf_mul(coef, dsr_q[i - int'(shift)]));
                end
            end
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

// ==== hdl/bch_euclid_solver.sv ====
`include "bch_consts.svh"

module bch_euclid_solver (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              syn_valid,
    input  gf_pkg::gf_poly_t  syn_poly,
    output logic              sigma_valid,
    output bch_pkg::sigma_t   sigma
);
    import gf_pkg::*;
    import bch_pkg::*;

    localparam gf_elem_t ZERO_E    = gf_elem_t'(`GF_ORDER);
    localparam gf_elem_t ONE_E     = '0;
    localparam gf_poly_t POLY_ZERO = '1;
    localparam gf_poly_t POLY_ONE  = {{(`POLY_LEN-1){ZERO_E}}, ONE_E};
    localparam gf_poly_t POLY_X6   = {ONE_E, {(`POLY_LEN-1){ZERO_E}}};

    solver_state_t state;
    logic [2:0]    k;          // quotient term being folded in
    logic [2:0]    q_deg;
    logic          last_term;
    logic          stop;
    logic          early_stop;

    logic          div_start;
    logic          div_done;
    gf_poly_t      quotient;
    gf_poly_t      remainder;

    gf_poly_t      r_prev;
    gf_poly_t      r_cur;
    gf_poly_t      s_prev;
    gf_poly_t      s_cur;
    gf_poly_t      s_acc;
    gf_poly_t      s_next;

    gf_poly_divider u_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .dividend  (r_prev),
        .divisor   (r_cur),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign q_deg      = poly_degree(quotient);
    assign last_term  = (k == q_deg);
    assign stop       = poly_degree(remainder) < 3'(`BCH_T);
    assign early_stop = poly_degree(syn_poly) < 3'(`BCH_T); // zero syndromes too

    // s_prev - q*s_cur, minus is xor in char 2
    always_comb begin
        s_next = s_acc;
        for (int i = 0; i < `POLY_LEN; i++) begin
            if (i >= int'(k)) begin
                s_next[i] = gf_add(s_acc[i], gf_mul(quotient[k], s_cur[i - int'(k)]));
            end
        end
    end

    // ==============================
    // control fsm
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            k           <= '0;
            div_start   <= 1'b0;
            sigma_valid <= 1'b0;
        end else begin
            div_start   <= 1'b0;
            sigma_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (syn_valid) begin
                        if (early_stop) begin
                            sigma_valid <= 1'b1; // sigma = 1, nothing to correct
                        end else begin
                            state     <= ST_DIVIDE;
                            div_start <= 1'b1;
                        end
                    end
                end
                ST_DIVIDE: begin
                    if (div_done) begin
                        state <= ST_UPDATE;
                        k     <= '0;
                    end
                end
                ST_UPDATE: begin
                    k <= k + 3'd1;
                    if (last_term) begin
                        if (stop) begin
                            state <= ST_DONE;
                        end else begin
                            state     <= ST_DIVIDE;
                            div_start <= 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    sigma_valid <= 1'b1;
                    state       <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ==============================
    // remainder and locator pairs
    // ==============================
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (syn_valid) begin
                    r_prev <= POLY_X6;
                    r_cur  <= syn_poly;
                    s_prev <= POLY_ZERO;
                    s_cur  <= POLY_ONE;
                    if (early_stop) sigma <= POLY_ONE[`LOC_LEN-1:0];
                end
            end
            ST_DIVIDE: begin
                if (div_done) s_acc <= s_prev;
            end
            ST_UPDATE: begin
                s_acc <= s_next;
                if (last_term) begin // rotate both pairs
                    s_prev <= s_cur;
                    s_cur  <= s_next;
                    r_prev <= r_cur;
                    r_cur  <= remainder;
                end
            end
            ST_DONE: sigma <= s_cur[`LOC_LEN-1:0];
            default: ;
        endcase
    end

endmodule

// ==== hdl/bch_chien_search.sv ====
`include "bch_consts.svh"

module bch_chien_search (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sigma_valid,
    input  bch_pkg::sigma_t    sigma,
    output logic               out_valid,
    output bch_pkg::err_loc_t  out_location
);
    import gf_pkg::*;
    import bch_pkg::*;

    sigma_t           sig_q;
    loc_list_t        list_q;
    loc_list_t        list_next;
    logic             searching;
    err_loc_t         pos;       // position under test
    logic [1:0]       hit_cnt;
    logic [1:0]       out_cnt;
    logic [`GF_M-1:0] eval_sum;  // sigma(alpha^-pos), polynomial basis
    logic             hit;

    always_comb begin
        int e;
        eval_sum = '0;
        for (int i = 0; i < `LOC_LEN; i++) begin
            e = (i * (`GF_ORDER - int'(pos))) % `GF_ORDER;
            eval_sum = eval_sum ^ gf_exp(gf_mul(sig_q[i], gf_elem_t'(e)));
        end
        hit = (eval_sum == '0);
        list_next = list_q;
        if (hit && hit_cnt < 2'(`BCH_T)) list_next[hit_cnt] = pos; // ascending by scan order
    end

    // ==============================
    // search then play out
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            searching    <= 1'b0;
            pos          <= '0;
            hit_cnt      <= '0;
            out_cnt      <= '0;
            out_valid    <= 1'b0;
            out_location <= '0;
        end else if (sigma_valid) begin
            searching <= 1'b1;
            pos       <= '0;
            hit_cnt   <= '0;
        end else if (searching) begin
            pos <= pos + 4'd1;
            if (hit && hit_cnt < 2'(`BCH_T)) hit_cnt <= hit_cnt + 2'd1;
            if (pos == err_loc_t'(`GF_ORDER - 1)) begin
                searching    <= 1'b0;
                out_valid    <= 1'b1;
                out_location <= list_next[0]; // last position may land here
                out_cnt      <= 2'd1;
            end
        end else if (out_valid) begin
            if (out_cnt == 2'(`BCH_T)) begin
                out_valid    <= 1'b0;
                out_location <= '0;
            end else begin
                out_location <= list_q[out_cnt];
                out_cnt      <= out_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sigma_valid) begin
            sig_q  <= sigma;
            list_q <= '1; // empty slots read 15
        end else if (searching) begin
            list_q <= list_next;
        end
    end

endmodule

// ==== hdl/bch_decoder.sv ====
module bch_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  gf_pkg::gf_elem_t   in_syndrome,
    output logic               out_valid,
    output bch_pkg::err_loc_t  out_location
);
    import gf_pkg::*;
    import bch_pkg::*;

    logic     syn_valid;
    gf_poly_t syn_poly;
    logic     sigma_valid;
    sigma_t   sigma;

    bch_syndrome_load u_syndrome_load (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_syndrome (in_syndrome),
        .syn_valid   (syn_valid),
        .syn_poly    (syn_poly)
    );

    // key equation, variable latency
    bch_euclid_solver u_solver (
        .clk         (clk),
        .rst_n       (rst_n),
        .syn_valid   (syn_valid),
        .syn_poly    (syn_poly),
        .sigma_valid (sigma_valid),
        .sigma       (sigma)
    );

    bch_chien_search u_chien (
        .clk          (clk),
        .rst_n        (rst_n),
        .sigma_valid  (sigma_valid),
        .sigma        (sigma),
        .out_valid    (out_valid),
        .out_location (out_location)
    );

endmodule

// ==== dv/bch_decoder_sva.sv ====
module bch_decoder_sva (
    input logic              clk,
    input logic              rst_n,
    input logic              out_valid,
    input bch_pkg::err_loc_t out_location
);

    int assert_errs = 0;

    // ==============================
    // output shape
    // ==============================

    // three positions, one per cycle, then low again
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> out_valid [*3] ##1 !out_valid)
    else begin
        $error("out_valid run is not 3 cycles long");
        assert_errs++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_location == '0)
    else begin
        $error("out_location nonzero while out_valid is low");
        assert_errs++;
    end

    // no disable here, reset itself is the condition
    assert property (@(posedge clk) !rst_n |-> !out_valid)
    else begin
        $error("out_valid high during reset");
        assert_errs++;
    end

endmodule

bind bch_decoder bch_decoder_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .out_valid    (out_valid),
    .out_location (out_location)
);

// ==== dv/bch_decoder_tb.sv ====
`include "bch_consts.svh"

module bch_decoder_tb;
    import gf_pkg::*;
    import bch_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_VEC      = 11;
    localparam int MAX_WAIT     = 300; // cycles allowed per entry
    localparam int IDLE_GAP     = 2;

    typedef struct packed {
        logic [1:0] n_err;
        loc_list_t  errs;     // error positions, any order
        loc_list_t  exp_list; // sorted, padded with 15
    } vec_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    gf_elem_t in_syndrome;
    logic     out_valid;
    err_loc_t out_location;

    vec_t vec_tbl [NUM_VEC];
    int   err_cnt;
    int   pass_cnt;
    int   fail_cnt;

    bch_decoder dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_syndrome  (in_syndrome),
        .out_valid    (out_valid),
        .out_location (out_location)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // reference gf(16) model
    // ==============================

    // alpha^e by repeated multiply by x, reduced by x^4 + x + 1
    function automatic logic [3:0] alpha_pow(int e);
        logic [3:0] v;
        v = 4'h1;
        for (int n = 0; n < e % 15; n++) begin
            v = {v[2:0], 1'b0} ^ (v[3] ? 4'h3 : 4'h0);
        end
        return v;
    endfunction

    function automatic gf_elem_t to_log(logic [3:0] v);
        gf_elem_t k;
        k = gf_elem_t'(`GF_ORDER); // zero element
        for (int n = 0; n < `GF_ORDER; n++) begin
            if (alpha_pow(n) == v) k = gf_elem_t'(n);
        end
        return k;
    endfunction

    // s_i = xor over errors j of alpha^(i*j)
    function automatic gf_elem_t ref_syndrome(vec_t v, int i);
        logic [3:0] acc;
        acc = 4'h0;
        for (int n = 0; n < int'(v.n_err); n++) begin
            acc = acc ^ alpha_pow(i * int'(v.errs[n]));
        end
        return to_log(acc);
    endfunction

    task automatic set_vec(int idx, int n, int e0, int e1, int e2, int x0, int x1, int x2);
        vec_tbl[idx].n_err       = 2'(n);
        vec_tbl[idx].errs[0]     = err_loc_t'(e0);
        vec_tbl[idx].errs[1]     = err_loc_t'(e1);
        vec_tbl[idx].errs[2]     = err_loc_t'(e2);
        vec_tbl[idx].exp_list[0] = err_loc_t'(x0);
        vec_tbl[idx].exp_list[1] = err_loc_t'(x1);
        vec_tbl[idx].exp_list[2] = err_loc_t'(x2);
    endtask

    task automatic check_location(err_loc_t got, err_loc_t exp);
        if (got !== exp) begin
            $display("error @%0t: out_location is %0d, expected %0d", $time, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(int got, int exp);
        if (got != exp) begin
            $display("error @%0t: out_valid high for %0d cycles, expected %0d", $time, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report(string name, int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: mismatch", name);
        end
    endtask

    task automatic run_vec(int idx);
        int  errs_before;
        int  waited;
        int  slot;
        bit  seen;
        errs_before = err_cnt;
        for (int i = 1; i <= `SYN_CNT; i++) begin
            @(posedge clk);
            in_valid    <= 1'b1;
            in_syndrome <= ref_syndrome(vec_tbl[idx], i);
        end
        @(posedge clk);
        in_valid    <= 1'b0;
        in_syndrome <= '0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
            if (out_valid) seen = 1'b1;
            else check_location(out_location, '0); // idle output stays 0
        end
        if (!seen) begin
            $display("entry %0d never raised out_valid within %0d cycles", idx, MAX_WAIT);
            err_cnt++;
        end else begin
            slot = 0;
            while (out_valid) begin
                if (slot < `BCH_T) check_location(out_location, vec_tbl[idx].exp_list[slot]);
                slot++;
                @(negedge clk);
            end
            check_count(slot, `BCH_T);
            check_location(out_location, '0);
        end
        repeat (IDLE_GAP) @(posedge clk);
        report($sformatf("entry %0d (%0d errors)", idx, vec_tbl[idx].n_err), errs_before);
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int errs_before;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_syndrome = '0;
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        set_vec(0, 0, 0, 0, 0, 15, 15, 15);   // clean block
        set_vec(1, 1, 0, 0, 0, 0, 15, 15);
        set_vec(2, 1, 7, 0, 0, 7, 15, 15);
        set_vec(3, 1, 14, 0, 0, 14, 15, 15);
        set_vec(4, 2, 11, 3, 0, 3, 11, 15);
        set_vec(5, 2, 14, 0, 0, 0, 14, 15);
        set_vec(6, 3, 14, 0, 6, 0, 6, 14);    // both end positions
        set_vec(7, 3, 9, 2, 5, 2, 5, 9);
        set_vec(8, 3, 13, 1, 12, 1, 12, 13);
        set_vec(9, 1, 4, 0, 0, 4, 15, 15);    // right after a full block
        set_vec(10, 0, 0, 0, 0, 15, 15, 15);

        errs_before = err_cnt;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("error @%0t: out_valid high during reset", $time);
            err_cnt++;
        end
        check_location(out_location, '0);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_location(out_location, '0);
        report("reset", errs_before);

        for (int idx = 0; idx < NUM_VEC; idx++) begin
            run_vec(idx);
        end

        $display("tests: %0d, passed: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
                 NUM_VEC + 1, pass_cnt, fail_cnt, err_cnt, dut_i.u_sva.assert_errs);
        if (err_cnt == 0 && fail_cnt == 0 && dut_i.u_sva.assert_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // whole run bounded by reset plus worst case per entry
    initial begin
        #((RESET_CYCLES + NUM_VEC * MAX_WAIT) * CLK_PERIOD);
        $display("watchdog expired, the decoder stopped responding");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== bch_decoder.f ====
+incdir+hdl
hdl/gf_pkg.sv
hdl/bch_pkg.sv
hdl/bch_syndrome_load.sv
hdl/gf_poly_divider.sv
hdl/bch_euclid_solver.sv
hdl/bch_chien_search.sv
hdl/bch_decoder.sv
dv/bch_decoder_sva.sv
dv/bch_decoder_tb.sv
